// File: hdl/uart_pkg.sv
// shared widths, register map and reset values; baud divisor must be at least 4 clocks per bit
package uart_pkg;

  localparam int axi_addr_width  = 5;
  localparam int axi_data_width  = 32;
  localparam int axi_resp_width  = 2;
  localparam int uart_data_width = 8;   // fixed 8-bit character
  localparam int div_width       = 16;
  localparam int fifo_depth      = 8;   // power of two, pointers wrap
  localparam int fifo_addr_width = $clog2(fifo_depth);

  localparam logic [axi_resp_width-1:0] resp_okay = 2'b00;

  // 115200 baud from a 25 MHz clock
  localparam logic [div_width-1:0] baud_div_init = 16'd217;

  localparam logic [axi_addr_width-1:0] addr_rbr_thr = 5'h00;
  localparam logic [axi_addr_width-1:0] addr_ier     = 5'h04;
  localparam logic [axi_addr_width-1:0] addr_div     = 5'h08;  // visible with dlab set
  localparam logic [axi_addr_width-1:0] addr_lcr     = 5'h0C;
  localparam logic [axi_addr_width-1:0] addr_lsr     = 5'h14;

  // line control bits
  localparam int lcr_two_stop   = 2;
  localparam int lcr_parity_en  = 3;
  localparam int lcr_parity_odd = 4;
  localparam int lcr_dlab       = 7;

  // line status bits
  localparam int lsr_data_ready = 0;
  localparam int lsr_thre       = 5;
  localparam int lsr_temt       = 6;

  typedef logic [uart_data_width-1:0] uart_byte_t;
  typedef logic [div_width-1:0]       baud_div_t;

endpackage

// File: hdl/uart_fifo.sv
// push when full and pop when empty are ignored; data_o shows the head entry
`timescale 1ns/1ns

module uart_fifo import uart_pkg::*; (
  input  logic       fixed_clk_i,
  input  logic       axi_aresetn_i,
  input  logic       push_i,
  input  uart_byte_t data_i,
  input  logic       pop_i,
  output uart_byte_t data_o,
  output logic       empty_o,
  output logic       full_o
);

  uart_byte_t                 mem [fifo_depth];
  logic [fifo_addr_width-1:0] wr_ptr, rd_ptr;
  logic [fifo_addr_width:0]   count;
  logic                       do_push, do_pop;

  assign empty_o = (count == '0);
  assign full_o  = (count == (fifo_addr_width+1)'(fifo_depth));
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;
  assign data_o  = mem[rd_ptr];

  always_ff @(posedge fixed_clk_i) begin
    if (do_push) mem[wr_ptr] <= data_i;
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;             // both or neither
      endcase
    end
  end

endmodule

// File: hdl/uart_tx.sv
// 8-bit frames lsb first; divisor and frame options are taken when a byte is popped
`timescale 1ns/1ns

module uart_tx import uart_pkg::*; (
  input  logic       fixed_clk_i,
  input  logic       axi_aresetn_i,
  input  uart_byte_t data_i,
  input  logic       empty_i,
  output logic       pop_o,
  input  baud_div_t  baud_div_i,
  input  logic       parity_en_i,
  input  logic       parity_odd_i,
  input  logic       two_stop_i,
  output logic       busy_o,
  output logic       uart_tx_o
);

  typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} tx_state_t;

  tx_state_t  state;
  baud_div_t  cnt, div_q;
  uart_byte_t shift_q;
  logic [2:0] bit_idx;
  logic       par_bit_q, par_en_q, two_stop_q;
  logic       stop_left;    // a second stop bit still to send
  logic       tx_q;

  assign pop_o     = (state == st_idle) && !empty_i;
  assign busy_o    = (state != st_idle);
  assign uart_tx_o = tx_q;

  // frame payload, loaded with the pop
  always_ff @(posedge fixed_clk_i) begin
    if (pop_o) begin
      shift_q    <= data_i;
      div_q      <= baud_div_i;
      par_bit_q  <= ^data_i ^ parity_odd_i;
      par_en_q   <= parity_en_i;
      two_stop_q <= two_stop_i;
    end else if (state == st_data && cnt == '0) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state     <= st_idle;
      tx_q      <= 1'b1;      // line idles high
      cnt       <= '0;
      bit_idx   <= '0;
      stop_left <= 1'b0;
    end else if (state == st_idle) begin
      if (pop_o) begin
        state   <= st_start;
        tx_q    <= 1'b0;
        cnt     <= baud_div_i - 1'b1;
        bit_idx <= '0;
      end
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end else begin
      cnt <= div_q - 1'b1;    // next bit period
      case (state)
        st_start: begin
          state <= st_data;
          tx_q  <= shift_q[0];
        end
        st_data: begin
          if (bit_idx == 3'd7) begin
            if (par_en_q) begin
              state <= st_parity;
              tx_q  <= par_bit_q;
            end else begin
              state     <= st_stop;
              tx_q      <= 1'b1;
              stop_left <= two_stop_q;
            end
          end else begin
            bit_idx <= bit_idx + 1'b1;
            tx_q    <= shift_q[1];
          end
        end
        st_parity: begin
          state     <= st_stop;
          tx_q      <= 1'b1;
          stop_left <= two_stop_q;
        end
        st_stop: begin
          if (stop_left) stop_left <= 1'b0;
          else           state     <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// File: hdl/uart_rx.sv
// samples mid-bit from a falling start edge; bad parity or a low stop bit drops the frame
`timescale 1ns/1ns

module uart_rx import uart_pkg::*; (
  input  logic       fixed_clk_i,
  input  logic       axi_aresetn_i,
  input  logic       uart_rx_i,
  input  baud_div_t  baud_div_i,
  input  logic       parity_en_i,
  input  logic       parity_odd_i,
  input  logic       two_stop_i,
  output logic       push_o,
  output uart_byte_t data_o
);

  typedef enum logic [2:0] {st_idle, st_start, st_data, st_parity, st_stop} rx_state_t;

  rx_state_t  state;
  logic       rx_s1, rx_s2, rx_prev;
  logic       start_edge;
  baud_div_t  cnt, div_q;
  uart_byte_t shift_q;
  logic [2:0] bit_idx;
  logic       par_en_q, par_odd_q, two_stop_q;
  logic       par_acc;      // running xor of data bits
  logic       err_q;
  logic       stop_left;

  assign start_edge = rx_prev && !rx_s2;
  assign data_o     = shift_q;

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= uart_rx_i;   // two-flop synchronizer
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (state == st_idle && start_edge) begin
      div_q      <= baud_div_i;
      par_en_q   <= parity_en_i;
      par_odd_q  <= parity_odd_i;
      two_stop_q <= two_stop_i;
    end
    if (state == st_data && cnt == '0) shift_q <= {rx_s2, shift_q[7:1]};
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      state     <= st_idle;
      cnt       <= '0;
      bit_idx   <= '0;
      par_acc   <= 1'b0;
      err_q     <= 1'b0;
      stop_left <= 1'b0;
      push_o    <= 1'b0;
    end else begin
      push_o <= 1'b0;
      if (state == st_idle) begin
        if (start_edge) begin
          state   <= st_start;
          cnt     <= (baud_div_i >> 1) - 1'b1;  // half a bit
          bit_idx <= '0;
          par_acc <= 1'b0;
          err_q   <= 1'b0;
        end
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end else begin
        cnt <= div_q - 1'b1;
        case (state)
          st_start: state <= rx_s2 ? st_idle : st_data;  // glitch rejected
          st_data: begin
            par_acc <= par_acc ^ rx_s2;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state     <= par_en_q ? st_parity : st_stop;
              stop_left <= two_stop_q;
            end
          end
          st_parity: begin
            if ((par_acc ^ rx_s2) != par_odd_q) err_q <= 1'b1;
            state <= st_stop;
          end
          st_stop: begin
            if (!rx_s2) begin
              state <= st_idle;   // framing error, no push
            end else if (stop_left) begin
              stop_left <= 1'b0;
            end else begin
              push_o <= !err_q;
              state  <= st_idle;
            end
          end
          default: state <= st_idle;
        endcase
      end
    end
  end

endmodule

// File: hdl/uart_reg_ctrl.sv
// THR writes stall while the tx FIFO is full; every response is OKAY, unmapped reads give zero
`timescale 1ns/1ns

module uart_reg_ctrl import uart_pkg::*; (
  input  logic                      fixed_clk_i,
  input  logic                      axi_aresetn_i,
  input  logic [axi_addr_width-1:0] axi_awaddr_i,
  input  logic                      axi_awvalid_i,
  output logic                      axi_awready_o,
  input  logic [axi_data_width-1:0] axi_wdata_i,
  input  logic                      axi_wvalid_i,
  output logic                      axi_wready_o,
  output logic [axi_resp_width-1:0] axi_bresp_o,
  output logic                      axi_bvalid_o,
  input  logic                      axi_bready_i,
  input  logic [axi_addr_width-1:0] axi_araddr_i,
  input  logic                      axi_arvalid_i,
  output logic                      axi_arready_o,
  output logic [axi_data_width-1:0] axi_rdata_o,
  output logic [axi_resp_width-1:0] axi_rresp_o,
  output logic                      axi_rvalid_o,
  input  logic                      axi_rready_i,
  output logic                      tx_push_o,
  output uart_byte_t                tx_data_o,
  input  logic                      tx_full_i,
  input  logic                      tx_empty_i,
  input  logic                      tx_busy_i,
  output logic                      rx_pop_o,
  input  uart_byte_t                rx_data_i,
  input  logic                      rx_empty_i,
  output baud_div_t                 baud_div_o,
  output logic                      parity_en_o,
  output logic                      parity_odd_o,
  output logic                      two_stop_o,
  output logic                      read_interrupt_o
);

  typedef enum logic {st_idle, st_resp} bus_state_t;

  bus_state_t                wr_state, rd_state;
  uart_byte_t                lcr_q;
  logic                      ier_q;       // receive-data interrupt enable
  baud_div_t                 div_q;
  logic                      dlab;
  logic                      wr_thr;
  logic                      wr_accept, rd_accept;
  logic [axi_data_width-1:0] lsr, rd_value;

  assign dlab      = lcr_q[lcr_dlab];
  assign wr_thr    = (axi_awaddr_i == addr_rbr_thr) && !dlab;
  // a THR write waits here while the FIFO is full
  assign wr_accept = (wr_state == st_idle) && axi_awvalid_i && axi_wvalid_i &&
                     !(wr_thr && tx_full_i);
  assign rd_accept = (rd_state == st_idle) && axi_arvalid_i;

  assign tx_push_o = wr_accept && wr_thr;
  assign tx_data_o = axi_wdata_i[uart_data_width-1:0];
  assign rx_pop_o  = rd_accept && (axi_araddr_i == addr_rbr_thr) && !dlab;

  assign baud_div_o   = div_q;
  assign parity_en_o  = lcr_q[lcr_parity_en];
  assign parity_odd_o = lcr_q[lcr_parity_odd];
  assign two_stop_o   = lcr_q[lcr_two_stop];

  assign axi_bresp_o = resp_okay;
  assign axi_rresp_o = resp_okay;

  always_comb begin
    lsr                 = '0;
    lsr[lsr_data_ready] = !rx_empty_i;
    lsr[lsr_thre]       = tx_empty_i;
    lsr[lsr_temt]       = tx_empty_i && !tx_busy_i;  // shifter idle too
  end

  always_comb begin
    rd_value = '0;
    case (axi_araddr_i)
      addr_rbr_thr: if (!dlab) rd_value[uart_data_width-1:0] = rx_data_i;
      addr_ier:     if (!dlab) rd_value[0] = ier_q;
      addr_div:     rd_value[div_width-1:0] = div_q;
      addr_lcr:     rd_value[uart_data_width-1:0] = lcr_q;
      addr_lsr:     rd_value = lsr;
      default:      rd_value = '0;   // unmapped
    endcase
  end

  // write channel and configuration registers
  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      wr_state      <= st_idle;
      axi_awready_o <= 1'b0;
      axi_wready_o  <= 1'b0;
      axi_bvalid_o  <= 1'b0;
      lcr_q         <= '0;
      ier_q         <= 1'b0;
      div_q         <= baud_div_init;
    end else begin
      axi_awready_o <= wr_accept;    // one-cycle pulse
      axi_wready_o  <= wr_accept;
      case (wr_state)
        st_idle: begin
          if (wr_accept) begin
            wr_state     <= st_resp;
            axi_bvalid_o <= 1'b1;
            case (axi_awaddr_i)
              addr_ier: if (!dlab) ier_q <= axi_wdata_i[0];
              addr_div: if (dlab) div_q <= axi_wdata_i[div_width-1:0];
              addr_lcr: lcr_q <= axi_wdata_i[uart_data_width-1:0];
              default:  ;            // THR handled by the push strobe
            endcase
          end
        end
        st_resp: begin
          if (axi_bready_i) begin
            axi_bvalid_o <= 1'b0;
            wr_state     <= st_idle;
          end
        end
        default: wr_state <= st_idle;
      endcase
    end
  end

  // read channel
  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) begin
      rd_state      <= st_idle;
      axi_arready_o <= 1'b0;
      axi_rvalid_o  <= 1'b0;
    end else begin
      axi_arready_o <= rd_accept;
      case (rd_state)
        st_idle: begin
          if (rd_accept) begin
            rd_state     <= st_resp;
            axi_rvalid_o <= 1'b1;
          end
        end
        st_resp: begin
          if (axi_rready_i) begin
            axi_rvalid_o <= 1'b0;
            rd_state     <= st_idle;
          end
        end
        default: rd_state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge fixed_clk_i) begin
    if (rd_accept) axi_rdata_o <= rd_value;  // held until the next read
  end

  always_ff @(posedge fixed_clk_i or negedge axi_aresetn_i) begin
    if (!axi_aresetn_i) read_interrupt_o <= 1'b0;
    else                read_interrupt_o <= ier_q && !rx_empty_i;
  end

endmodule

// File: hdl/axi_uart_top.sv
// single clock fixed_clk_i for bus and uart; no ids or strobes, unmapped reads return zero
`timescale 1ns/1ns

module axi_uart_top import uart_pkg::*; (
  input  logic                      fixed_clk_i,
  input  logic                      axi_aresetn_i,
  input  logic [axi_addr_width-1:0] axi_awaddr_i,
  input  logic                      axi_awvalid_i,
  output logic                      axi_awready_o,
  input  logic [axi_data_width-1:0] axi_wdata_i,
  input  logic                      axi_wvalid_i,
  output logic                      axi_wready_o,
  output logic [axi_resp_width-1:0] axi_bresp_o,
  output logic                      axi_bvalid_o,
  input  logic                      axi_bready_i,
  input  logic [axi_addr_width-1:0] axi_araddr_i,
  input  logic                      axi_arvalid_i,
  output logic                      axi_arready_o,
  output logic [axi_data_width-1:0] axi_rdata_o,
  output logic [axi_resp_width-1:0] axi_rresp_o,
  output logic                      axi_rvalid_o,
  input  logic                      axi_rready_i,
  input  logic                      uart_rx_i,
  output logic                      uart_tx_o,
  output logic                      read_interrupt_o
);

  logic       tx_push, tx_pop, tx_full, tx_empty, tx_busy;
  uart_byte_t tx_wdata, tx_head;
  logic       rx_push, rx_pop, rx_empty;
  uart_byte_t rx_byte, rx_head;
  baud_div_t  baud_div;
  logic       parity_en, parity_odd, two_stop;

  uart_reg_ctrl i_reg_ctrl (
    .fixed_clk_i      (fixed_clk_i),
    .axi_aresetn_i    (axi_aresetn_i),
    .axi_awaddr_i     (axi_awaddr_i),
    .axi_awvalid_i    (axi_awvalid_i),
    .axi_awready_o    (axi_awready_o),
    .axi_wdata_i      (axi_wdata_i),
    .axi_wvalid_i     (axi_wvalid_i),
    .axi_wready_o     (axi_wready_o),
    .axi_bresp_o      (axi_bresp_o),
    .axi_bvalid_o     (axi_bvalid_o),
    .axi_bready_i     (axi_bready_i),
    .axi_araddr_i     (axi_araddr_i),
    .axi_arvalid_i    (axi_arvalid_i),
    .axi_arready_o    (axi_arready_o),
    .axi_rdata_o      (axi_rdata_o),
    .axi_rresp_o      (axi_rresp_o),
    .axi_rvalid_o     (axi_rvalid_o),
    .axi_rready_i     (axi_rready_i),
    .tx_push_o        (tx_push),
    .tx_data_o        (tx_wdata),
    .tx_full_i        (tx_full),
    .tx_empty_i       (tx_empty),
    .tx_busy_i        (tx_busy),
    .rx_pop_o         (rx_pop),
    .rx_data_i        (rx_head),
    .rx_empty_i       (rx_empty),
    .baud_div_o       (baud_div),
    .parity_en_o      (parity_en),
    .parity_odd_o     (parity_odd),
    .two_stop_o       (two_stop),
    .read_interrupt_o (read_interrupt_o)
  );

  uart_fifo i_tx_fifo (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .push_i        (tx_push),
    .data_i        (tx_wdata),
    .pop_i         (tx_pop),
    .data_o        (tx_head),
    .empty_o       (tx_empty),
    .full_o        (tx_full)
  );

  uart_fifo i_rx_fifo (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .push_i        (rx_push),
    .data_i        (rx_byte),
    .pop_i         (rx_pop),
    .data_o        (rx_head),
    .empty_o       (rx_empty),
    .full_o        ()            // overflow bytes dropped inside the fifo
  );

  uart_tx i_uart_tx (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .data_i        (tx_head),
    .empty_i       (tx_empty),
    .pop_o         (tx_pop),
    .baud_div_i    (baud_div),
    .parity_en_i   (parity_en),
    .parity_odd_i  (parity_odd),
    .two_stop_i    (two_stop),
    .busy_o        (tx_busy),
    .uart_tx_o     (uart_tx_o)
  );

  uart_rx i_uart_rx (
    .fixed_clk_i   (fixed_clk_i),
    .axi_aresetn_i (axi_aresetn_i),
    .uart_rx_i     (uart_rx_i),
    .baud_div_i    (baud_div),
    .parity_en_i   (parity_en),
    .parity_odd_i  (parity_odd),
    .two_stop_i    (two_stop),
    .push_o        (rx_push),
    .data_o        (rx_byte)
  );

endmodule

// File: verification/axi_uart_asserts.sv
// handshake checks only; every property is sampled on the rising edge of fixed_clk_i
`timescale 1ns/1ns

module axi_uart_asserts (
  input logic fixed_clk_i,
  input logic axi_aresetn_i,
  input logic awready_i,
  input logic wready_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic arready_i,
  input logic rvalid_i,
  input logic rready_i
);

  bvalid_hold: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  aw_w_ready_pair: assert property (@(posedge fixed_clk_i) disable iff (!axi_aresetn_i)
    awready_i == wready_i)
    else $error("awready and wready differ");

  // first sampled cycle out of reset
  quiet_after_reset: assert property (@(posedge fixed_clk_i)
    $rose(axi_aresetn_i) |-> !(awready_i || wready_i || bvalid_i || arready_i || rvalid_i))
    else $error("ready or valid high right after reset");

endmodule

bind axi_uart_top axi_uart_asserts i_axi_uart_asserts (
  .fixed_clk_i   (fixed_clk_i),
  .axi_aresetn_i (axi_aresetn_i),
  .awready_i     (axi_awready_o),
  .wready_i      (axi_wready_o),
  .bvalid_i      (axi_bvalid_o),
  .bready_i      (axi_bready_i),
  .arready_i     (axi_arready_o),
  .rvalid_i      (axi_rvalid_o),
  .rready_i      (axi_rready_i)
);

// File: verification/axi_uart_tb.sv
// run from the project root; the serial model follows the last LCR and divisor written
`timescale 1ns/1ns

module axi_uart_tb import uart_pkg::*; ();

  logic                      fixed_clk;
  logic                      axi_aresetn;
  logic [axi_addr_width-1:0] axi_awaddr;
  logic                      axi_awvalid, axi_awready;
  logic [axi_data_width-1:0] axi_wdata;
  logic                      axi_wvalid, axi_wready;
  logic [axi_resp_width-1:0] axi_bresp;
  logic                      axi_bvalid, axi_bready;
  logic [axi_addr_width-1:0] axi_araddr;
  logic                      axi_arvalid, axi_arready;
  logic [axi_data_width-1:0] axi_rdata;
  logic [axi_resp_width-1:0] axi_rresp;
  logic                      axi_rvalid, axi_rready;
  logic                      uart_rx, uart_tx, read_interrupt;

  logic [7:0]  cmd_q [$];
  logic [31:0] arg_a_q [$];
  logic [31:0] arg_b_q [$];
  uart_byte_t  tx_seen [$];                  // frames caught on uart_tx_o
  uart_byte_t  model_lcr     = '0;
  baud_div_t   model_div     = baud_div_init;
  logic [31:0] lfsr_state    = 32'h3689_919c;
  int          cycle_count   = 0;
  int          timeout_limit = 0;
  int          fail_count    = 0;

  axi_uart_top i_axi_uart_top (
    .fixed_clk_i      (fixed_clk),
    .axi_aresetn_i    (axi_aresetn),
    .axi_awaddr_i     (axi_awaddr),
    .axi_awvalid_i    (axi_awvalid),
    .axi_awready_o    (axi_awready),
    .axi_wdata_i      (axi_wdata),
    .axi_wvalid_i     (axi_wvalid),
    .axi_wready_o     (axi_wready),
    .axi_bresp_o      (axi_bresp),
    .axi_bvalid_o     (axi_bvalid),
    .axi_bready_i     (axi_bready),
    .axi_araddr_i     (axi_araddr),
    .axi_arvalid_i    (axi_arvalid),
    .axi_arready_o    (axi_arready),
    .axi_rdata_o      (axi_rdata),
    .axi_rresp_o      (axi_rresp),
    .axi_rvalid_o     (axi_rvalid),
    .axi_rready_i     (axi_rready),
    .uart_rx_i        (uart_rx),
    .uart_tx_o        (uart_tx),
    .read_interrupt_o (read_interrupt)
  );

  initial begin
    fixed_clk = 1'b0;
    forever #20 fixed_clk = ~fixed_clk;     // 40 ns period
  end

  task automatic report_failure(input string msg);
    fail_count++;
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
      report_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, actual, expected));
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic int random_bits(input int nbits);
    int value;
    int i;
    value = 0;
    for (i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = (value << 1) | lfsr_state[0];
    end
    return value;
  endfunction

  // bit that makes the count of ones even, or odd with odd parity
  function automatic logic parity_bit(input uart_byte_t value, input logic odd);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < uart_data_width; i++) ones += value[i];
    return (ones % 2 == 1) != odd;
  endfunction

  task automatic wait_cycle();
    @(posedge fixed_clk);
    #5;                                     // drive and sample clear of the edge
  endtask

  task automatic write_reg(input logic [axi_addr_width-1:0] addr, input logic [31:0] data);
    int delay;
    axi_awaddr  = addr;
    axi_wdata   = data;
    axi_awvalid = 1'b1;
    axi_wvalid  = 1'b1;
    wait_cycle();
    while (!axi_awready) wait_cycle();      // stalls here while the tx FIFO is full
    axi_awvalid = 1'b0;
    axi_wvalid  = 1'b0;
    check_value("axi_wready_o", axi_wready, 1);
    check_value("axi_bvalid_o", axi_bvalid, 1);
    check_value("axi_bresp_o", axi_bresp, resp_okay);
    delay = random_bits(2);
    repeat (delay) wait_cycle();
    axi_bready = 1'b1;
    wait_cycle();
    axi_bready = 1'b0;
    check_value("axi_bvalid_o", axi_bvalid, 0);
  endtask

  task automatic read_reg(input logic [axi_addr_width-1:0] addr, output logic [31:0] data);
    int delay;
    axi_araddr  = addr;
    axi_arvalid = 1'b1;
    wait_cycle();
    while (!axi_arready) wait_cycle();
    axi_arvalid = 1'b0;
    check_value("axi_rvalid_o", axi_rvalid, 1);
    check_value("axi_rresp_o", axi_rresp, resp_okay);
    data  = axi_rdata;
    delay = random_bits(2);
    repeat (delay) wait_cycle();
    axi_rready = 1'b1;
    wait_cycle();
    axi_rready = 1'b0;
    check_value("axi_rvalid_o", axi_rvalid, 0);
  endtask

  task automatic drive_bit(input logic value);
    uart_rx = value;
    repeat (model_div) wait_cycle();
  endtask

  // mode 1 flips the parity bit, mode 2 sends a low first stop bit
  task automatic send_frame(input uart_byte_t value, input logic [31:0] mode);
    logic par;
    int   i;
    par = parity_bit(value, model_lcr[lcr_parity_odd]);
    if (mode == 1) par = ~par;
    drive_bit(1'b0);
    for (i = 0; i < uart_data_width; i++) drive_bit(value[i]);  // lsb first
    if (model_lcr[lcr_parity_en]) drive_bit(par);
    drive_bit(mode != 2);
    if (model_lcr[lcr_two_stop]) drive_bit(1'b1);
    drive_bit(1'b1);                        // idle gap
  endtask

  initial begin : tx_monitor
    uart_byte_t value;
    baud_div_t  div;
    logic       par_en, par_odd, two_stop;
    int         i;
    wait (axi_aresetn === 1'b1);
    forever begin
      @(negedge uart_tx);
      div      = model_div;
      par_en   = model_lcr[lcr_parity_en];
      par_odd  = model_lcr[lcr_parity_odd];
      two_stop = model_lcr[lcr_two_stop];
      repeat (div / 2) @(negedge fixed_clk);  // middle of the start bit
      check_value("uart_tx_o start bit", uart_tx, 0);
      for (i = 0; i < uart_data_width; i++) begin
        repeat (div) @(negedge fixed_clk);
        value[i] = uart_tx;
      end
      if (par_en) begin
        repeat (div) @(negedge fixed_clk);
        check_value("uart_tx_o parity bit", uart_tx, parity_bit(value, par_odd));
      end
      repeat (div) @(negedge fixed_clk);
      check_value("uart_tx_o stop bit", uart_tx, 1);
      if (two_stop) begin
        repeat (div) @(negedge fixed_clk);
        check_value("uart_tx_o second stop bit", uart_tx, 1);
      end
      tx_seen.push_back(value);
    end
  end

  task automatic load_commands();
    int          fd;
    int          n;
    int          max_div;
    string       line;
    logic [7:0]  op;
    logic [31:0] arg_a, arg_b;
    max_div = baud_div_init;
    fd      = $fopen("verification/axi_uart_stimulus.txt", "r");
    if (fd == 0) begin
      report_failure("could not open verification/axi_uart_stimulus.txt");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h", op, arg_a, arg_b);
          if (n != 3) begin
            report_failure({"unreadable line in the stimulus file: ", line});
          end else begin
            cmd_q.push_back(op);
            arg_a_q.push_back(arg_a);
            arg_b_q.push_back(arg_b);
            if (op == "W" && arg_a == addr_div && arg_b > max_div) max_div = arg_b;
          end
        end
      end
      $fclose(fd);
      timeout_limit = cmd_q.size() * 13 * max_div + 2000;  // 13 bits per command
    end
  endtask

  task automatic run_command(input logic [7:0] op, input logic [31:0] arg_a,
                             input logic [31:0] arg_b);
    logic [31:0] data;
    case (op)
      "W": begin
        if (arg_a == addr_lcr) model_lcr = arg_b[uart_data_width-1:0];
        else if (arg_a == addr_div && model_lcr[lcr_dlab]) model_div = arg_b[div_width-1:0];
        write_reg(arg_a[axi_addr_width-1:0], arg_b);
      end
      "R": begin
        read_reg(arg_a[axi_addr_width-1:0], data);
        check_value("axi_rdata_o", data, arg_b);
      end
      "S": send_frame(arg_b[uart_data_width-1:0], arg_a);
      "T": begin
        while (tx_seen.size() == 0) wait_cycle();
        check_value("uart_tx_o byte", tx_seen.pop_front(), arg_b);
      end
      "I": begin
        wait_cycle();
        check_value("read_interrupt_o", read_interrupt, arg_b);
      end
      default: report_failure($sformatf("unknown command %c in the stimulus file", op));
    endcase
  endtask

  always @(posedge fixed_clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit != 0 && cycle_count >= timeout_limit)
      report_failure("timed out waiting for the DUT");
  end

  initial begin : stimulus
    int idx;
    axi_aresetn = 1'b0;
    axi_awaddr  = '0;
    axi_awvalid = 1'b0;
    axi_wdata   = '0;
    axi_wvalid  = 1'b0;
    axi_bready  = 1'b0;
    axi_araddr  = '0;
    axi_arvalid = 1'b0;
    axi_rready  = 1'b0;
    uart_rx     = 1'b1;                     // line idles high
    load_commands();
    repeat (8) @(posedge fixed_clk);
    #5;
    axi_aresetn = 1'b1;
    for (idx = 0; idx < cmd_q.size(); idx++) begin
      run_command(cmd_q[idx], arg_a_q[idx], arg_b_q[idx]);
    end
    check_value("frames left on uart_tx_o", tx_seen.size(), 0);
    if (fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verification/axi_uart_stimulus.txt
# columns: cmd a b, hex; W addr data, R addr expected, S mode byte (mode 1 bad parity, 2 low stop)
# T 0 expected tx byte, I 0 expected interrupt level
R 14 60
I 00 0
R 10 0
W 1c ff
R 0c 0
R 04 0
R 08 d9
W 0c 80
W 08 8
W 0c 03
W 08 20
R 08 8
W 00 55
W 00 a3
T 00 55
T 00 a3
W 0c 1c
W 00 c4
T 00 c4
W 0c 8c
W 00 77
W 0c 0c
W 00 3b
T 00 3b
W 0c 03
W 00 81
W 00 42
W 00 c3
W 00 24
W 00 a5
W 00 66
W 00 e7
W 00 18
W 00 99
T 00 81
T 00 42
T 00 c3
T 00 24
T 00 a5
T 00 66
T 00 e7
T 00 18
T 00 99
W 04 1
S 0 3c
S 0 e1
I 0 1
R 14 61
R 00 3c
R 00 e1
I 0 0
R 14 60
W 0c 08
S 1 5a
S 2 c3
R 14 60
S 0 96
R 00 96
R 14 60

// File: axi_uart_lite.f
hdl/uart_pkg.sv
hdl/uart_fifo.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/uart_reg_ctrl.sv
hdl/axi_uart_top.sv
verification/axi_uart_asserts.sv
verification/axi_uart_tb.sv

// File: Bender.yml
package:
  name: axi_uart_lite

sources:
  - hdl/uart_pkg.sv
  - hdl/uart_fifo.sv
  - hdl/uart_tx.sv
  - hdl/uart_rx.sv
  - hdl/uart_reg_ctrl.sv
  - hdl/axi_uart_top.sv
  - target: simulation
    files:
      - verification/axi_uart_asserts.sv
      - verification/axi_uart_tb.sv
